// File: sim.f
main_bus_pkg.sv
bus_cycle_fsm.sv
wait_timer.sv
region_decoder.sv
cab_io.sv
read_mux.sv
main_bus.sv
tb_main_bus.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the main bus testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_main_bus -f sim.f -o tb_main_bus

output="$(./obj_dir/tb_main_bus)"
echo "$output"

grep -q "Simulation passed" <<< "$output"

// File: tb_main_bus.sv
/* Testbench for the main-CPU bus glue, with ROM and RAM responders and a reference model.
   Random cycles come from a 32-bit Galois LFSR with a fixed seed; one cycle in flight. */
`timescale 1ns/1ps

module tb_main_bus;
    import main_bus_pkg::*;

    typedef enum {mode_random, mode_latch, mode_cabinet, mode_refused} test_mode_e;

    localparam int clk_period   = 100;
    localparam int cycles_total = 200 + 40 + 2 * 30 + 40;
    localparam int max_wait     = 32;   // Cycles before dtackn counts as lost

    logic        clk = 1'b0;
    logic        rst;
    logic        asn;
    bus_req_t    bus_req;
    logic [15:0] rom_data, ram_data, char_dout, pal_dout, obj_dout;
    logic        rom_ok, ram_ok;
    logic [7:0]  joystick1, dipsw_a, dipsw_b;
    logic [1:0]  coin_input, start_button;
    logic        service, dip_test;
    logic [15:0] joyana1, joyana2;
    cs_t         cs;
    logic [23:1] addr;
    logic [15:0] wdata, rdata;
    logic        rnw, dtackn, video_en, snd_rstb;
    logic [1:0]  dsn, obj_cfg;

    logic [31:0] lfsr;
    logic [2:0]  rom_delay, ram_delay, rom_cnt, ram_cnt;
    logic [7:0]  latch_m;               // Model of the port latch
    int          errors, checks, tests;

    main_bus main_bus_inst (
        .clk (clk), .rst (rst), .asn (asn), .bus_req (bus_req),
        .rom_data (rom_data), .rom_ok (rom_ok), .ram_data (ram_data), .ram_ok (ram_ok),
        .char_dout (char_dout), .pal_dout (pal_dout), .obj_dout (obj_dout),
        .joystick1 (joystick1), .coin_input (coin_input), .start_button (start_button),
        .service (service), .dip_test (dip_test), .dipsw_a (dipsw_a), .dipsw_b (dipsw_b),
        .joyana1 (joyana1), .joyana2 (joyana2),
        .cs (cs), .addr (addr), .wdata (wdata), .rnw (rnw), .dsn (dsn), .rdata (rdata),
        .dtackn (dtackn), .obj_cfg (obj_cfg), .video_en (video_en), .snd_rstb (snd_rstb)
    );

    always #(clk_period / 2) clk = ~clk;

    function logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h80200003;
        else
            return s >> 1;
    endfunction

    task draw(input int nbits, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    // Video RAM contents, folded from every address bit
    function logic [15:0] fill_word(input logic [23:1] a, input logic [15:0] salt);
        return a[16:1] ^ {a[23:17], a[9:1]} ^ salt;
    endfunction

    assign char_dout = fill_word(bus_req.addr, 16'h5a00);
    assign pal_dout  = fill_word(bus_req.addr, 16'h00a5);
    assign obj_dout  = fill_word(bus_req.addr, 16'hc3c3);

    // ROM and RAM answer after their drawn delay while selected
    initial begin
        rom_ok  = 1'b0;
        ram_ok  = 1'b0;
        rom_cnt = 3'd0;
        ram_cnt = 3'd0;
        forever begin
            @(negedge clk);
            if (cs.rom) begin
                if (rom_cnt >= rom_delay)
                    rom_ok = 1'b1;
                else
                    rom_cnt = rom_cnt + 3'd1;
            end else begin
                rom_ok  = 1'b0;
                rom_cnt = 3'd0;
            end
            if (cs.ram) begin
                if (ram_cnt >= ram_delay)
                    ram_ok = 1'b1;
                else
                    ram_cnt = ram_cnt + 3'd1;
            end else begin
                ram_ok  = 1'b0;
                ram_cnt = 3'd0;
            end
        end
    end

    task check(input string name, input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    task report_test(input string name, input int e0);
        tests++;
        if (errors == e0)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - e0);
    endtask

    function cs_t model_cs(input bus_req_t r);
        cs_t  c;
        logic any_ds;
        c      = '0;
        any_ds = (r.dsn != 2'b11);
        case (r.addr[23:21])
            3'd0: c.rom = r.rnw;        // Writes to ROM are refused
            3'd1: c.ram = any_ds;
            3'd2: begin
                c.chr  = r.addr[16];
                c.vram = !r.addr[16] && any_ds;
            end
            3'd3: c.pal = 1'b1;
            3'd4: c.obj = 1'b1;
            3'd5: c.io  = 1'b1;
            default: ;
        endcase
        c.none = (c == '0);
        return c;
    endfunction

    function logic [7:0] model_io(input bus_req_t r);
        logic [7:0] v;
        v = 8'hff;
        case (r.addr[6:4])
            3'd0: v = latch_m;
            3'd1: begin
                case (r.addr[2:1])
                    2'd0: v = {coin_input, 1'b0, joystick1[4], start_button[0],
                               service, dip_test, 1'b1};
                    2'd2: v = dipsw_a;
                    2'd3: v = dipsw_b;
                    default: v = 8'hff;
                endcase
            end
            3'd3: begin
                case (latch_m[4:2])     // ADC channel
                    3'd0: v = joyana1[7:0];
                    3'd1: v = joyana1[15:8] + adc_bias;
                    3'd2: v = joyana2[15:8] + adc_bias;
                    default: v = 8'hff;
                endcase
            end
            default: v = 8'hff;
        endcase
        return v;
    endfunction

    function logic [15:0] model_rdata(input cs_t c, input bus_req_t r);
        if (c.rom) return rom_data;
        if (c.ram || c.vram) return ram_data;
        if (c.chr) return fill_word(r.addr, 16'h5a00);
        if (c.pal) return fill_word(r.addr, 16'h00a5);
        if (c.obj) return fill_word(r.addr, 16'hc3c3);
        if (c.io) return {8'hff, model_io(r)};
        return open_bus;
    endfunction

    function bus_req_t make_req(input logic [2:0] top, input logic [19:0] low,
                                input logic [15:0] wd, input logic [1:0] ds, input logic rw);
        bus_req_t r;
        r.addr  = {top, low};
        r.wdata = wd;
        r.dsn   = ds;
        r.rnw   = rw;
        return r;
    endfunction

    task draw_cabinet();
        logic [31:0] v;
        draw(30, v);
        joystick1    = v[7:0];
        dipsw_a      = v[15:8];
        dipsw_b      = v[23:16];
        coin_input   = v[25:24];
        start_button = v[27:26];
        service      = v[28];
        dip_test     = v[29];
        draw(32, v);
        joyana1      = v[15:0];
        joyana2      = v[31:16];
    endtask

    // One full bus cycle, entered and left on a falling edge
    task run_cycle(input bus_req_t r);
        cs_t         exp_cs;
        logic [15:0] exp_rd;
        int          exp_n;
        int          n;
        logic [31:0] v;
        logic        latch_wr;
        draw(3, v);
        rom_delay = v[2:0];
        draw(3, v);
        ram_delay = v[2:0];
        draw(32, v);
        rom_data = v[15:0];
        ram_data = v[31:16];
        draw_cabinet();
        bus_req = r;
        asn     = 1'b0;
        exp_cs  = model_cs(r);
        exp_rd  = model_rdata(exp_cs, r);
        exp_n   = 5;                    // Decode, two waits, ack
        if (exp_cs.rom)
            exp_n = 3 + int'(rom_delay);
        if (exp_cs.ram)
            exp_n = 3 + int'(ram_delay);
        latch_wr = exp_cs.io && !r.rnw && !r.dsn[0] && r.addr[6:4] == 3'd0
                && r.addr[2:1] == 2'd0;
        n = 0;
        while (dtackn && n < max_wait) begin
            @(posedge clk);
            @(negedge clk);
            n++;
        end
        if (dtackn) begin
            errors++;
            $display("Cycle to address %h: dtackn stayed high for %0d cycles",
                     {r.addr, 1'b0}, max_wait);
        end else begin
            check("dtackn latency", exp_n, n);
            check("cs", 32'(exp_cs), 32'(cs));
            check("rdata", 32'(exp_rd), 32'(rdata));
            check("addr", 32'(r.addr), 32'(addr));
            check("wdata", 32'(r.wdata), 32'(wdata));
            check("rnw", 32'(r.rnw), 32'(rnw));
            check("dsn", 32'(r.dsn), 32'(dsn));
        end
        if (latch_wr)
            latch_m = r.wdata[7:0];
        draw(2, v);
        repeat (v[1:0]) begin           // Master stalls before releasing asn
            @(posedge clk);
            @(negedge clk);
            check("dtackn", 32'd0, 32'(dtackn));
            check("cs", 32'(exp_cs), 32'(cs));
        end
        asn = 1'b1;
        @(posedge clk);
        @(negedge clk);
        check("dtackn", 32'd1, 32'(dtackn));
        check("cs", 32'd0, 32'(cs));
        check("rdata", 32'(exp_rd), 32'(rdata));
        check("obj_cfg", 32'(latch_m[7:6]), 32'(obj_cfg));
        check("video_en", 32'(latch_m[5]), 32'(video_en));
        check("snd_rstb", 32'(latch_m[0]), 32'(snd_rstb));
    endtask

    task run_test(input string name, input test_mode_e mode, input int count);
        logic [31:0] v;
        logic [31:0] wd_raw;
        logic [2:0]  top;
        logic [19:0] low;
        logic [15:0] wd;
        logic [1:0]  ds;
        logic        rw;
        int          e0;
        e0 = errors;
        for (int i = 0; i < count; i++) begin
            draw(30, v);
            low = v[19:0];              // addr[20:1]
            top = v[22:20];
            ds  = v[24:23];
            rw  = v[25];
            draw(16, wd_raw);
            wd  = wd_raw[15:0];
            case (mode)
                mode_latch: begin
                    top = map_io;
                    if (v[26])
                        low = {low[19:6], 3'd0, low[2], 2'b00};
                end
                mode_cabinet: begin
                    // Set the ADC channel, then read switches or ADC
                    run_cycle(make_req(map_io, {low[19:6], 3'd0, low[2], 2'b00}, wd,
                                       {ds[1], 1'b0}, 1'b0));
                    top = map_io;
                    rw  = 1'b1;
                    low = {low[19:6], v[26] ? 3'd3 : 3'd1, low[2:0]};
                end
                mode_refused: begin
                    case (v[28:27])
                        2'd0: begin
                            top = map_rom;
                            rw  = 1'b0;
                        end
                        2'd1: top = {2'b11, v[29]};
                        2'd2: begin
                            top = map_ram;
                            ds  = 2'b11;
                        end
                        default: begin
                            top     = map_scr;
                            low[15] = 1'b0;     // VRAM half
                            ds      = 2'b11;
                        end
                    endcase
                end
                default: ;
            endcase
            run_cycle(make_req(top, low, wd, ds, rw));
        end
        report_test(name, e0);
    endtask

    initial begin
        int e0;
        rst          = 1'b1;
        asn          = 1'b1;
        bus_req      = '0;
        rom_data     = '0;
        ram_data     = '0;
        joystick1    = '0;
        coin_input   = '0;
        start_button = '0;
        service      = 1'b0;
        dip_test     = 1'b0;
        dipsw_a      = '0;
        dipsw_b      = '0;
        joyana1      = '0;
        joyana2      = '0;
        rom_delay    = '0;
        ram_delay    = '0;
        latch_m      = '0;
        lfsr         = 32'd69895;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        e0 = errors;
        check("dtackn", 32'd1, 32'(dtackn));
        check("cs", 32'd0, 32'(cs));
        check("rdata", 32'd0, 32'(rdata));
        check("video_en", 32'd0, 32'(video_en));
        check("snd_rstb", 32'd0, 32'(snd_rstb));
        report_test("reset", e0);
        run_test("random cycles", mode_random, 200);
        run_test("latch writes", mode_latch, 40);
        run_test("cabinet reads", mode_cabinet, 30);
        run_test("refused cycles", mode_refused, 40);
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Twenty clock periods per bus cycle, plus reset
    initial begin
        #((cycles_total + 10) * 20 * clk_period);
        $display("Watchdog timeout: the tests did not finish in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: main_bus.sv
/* Main-CPU bus glue of the racing board, CPU not included.
   One cycle in flight; bus_req must stay stable while asn is low.
   ROM and RAM answer through rom_ok and ram_ok, video blocks have no ok. */
`timescale 1ns/1ps

module main_bus (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   asn,
    input  main_bus_pkg::bus_req_t bus_req,
    input  logic [15:0]            rom_data,
    input  logic                   rom_ok,
    input  logic [15:0]            ram_data,
    input  logic                   ram_ok,
    input  logic [15:0]            char_dout,
    input  logic [15:0]            pal_dout,
    input  logic [15:0]            obj_dout,
    input  logic [7:0]             joystick1,
    input  logic [1:0]             coin_input,
    input  logic [1:0]             start_button,
    input  logic                   service,
    input  logic                   dip_test,
    input  logic [7:0]             dipsw_a,
    input  logic [7:0]             dipsw_b,
    input  logic [15:0]            joyana1,
    input  logic [15:0]            joyana2,
    output main_bus_pkg::cs_t      cs,
    output logic [23:1]            addr,
    output logic [15:0]            wdata,
    output logic                   rnw,
    output logic [1:0]             dsn,
    output logic [15:0]            rdata,
    output logic                   dtackn,
    output logic [1:0]             obj_cfg,
    output logic                   video_en,
    output logic                   snd_rstb
);
    import main_bus_pkg::*;

    region_e    region;
    logic       decode_en;
    logic       timer_start;
    logic       timer_done;
    logic       load_en;
    logic       cycle_end;
    logic       wr_stb;
    logic [7:0] io_dout;

    // Memory side sees the master's levels directly
    assign addr  = bus_req.addr;
    assign wdata = bus_req.wdata;
    assign rnw   = bus_req.rnw;
    assign dsn   = bus_req.dsn;

    assign wr_stb = load_en && !bus_req.rnw;    // rnw held for the whole cycle

    bus_cycle_fsm fsm_inst (
        .clk         (clk),
        .rst         (rst),
        .asn         (asn),
        .region      (region),
        .rnw         (bus_req.rnw),
        .rom_ok      (rom_ok),
        .ram_ok      (ram_ok),
        .timer_done  (timer_done),
        .decode_en   (decode_en),
        .timer_start (timer_start),
        .load_en     (load_en),
        .cycle_end   (cycle_end),
        .dtackn      (dtackn)
    );

    wait_timer timer_inst (
        .clk         (clk),
        .rst         (rst),
        .timer_start (timer_start),
        .timer_done  (timer_done)
    );

    region_decoder decoder_inst (
        .clk       (clk),
        .rst       (rst),
        .decode_en (decode_en),
        .cycle_end (cycle_end),
        .req       (bus_req),
        .region    (region),
        .cs        (cs)
    );

    cab_io cab_inst (
        .clk          (clk),
        .rst          (rst),
        .io_cs        (cs.io),
        .wr_stb       (wr_stb),
        .req          (bus_req),
        .joystick1    (joystick1),
        .coin_input   (coin_input),
        .start_button (start_button),
        .service      (service),
        .dip_test     (dip_test),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .joyana1      (joyana1),
        .joyana2      (joyana2),
        .io_dout      (io_dout),
        .obj_cfg      (obj_cfg),
        .video_en     (video_en),
        .snd_rstb     (snd_rstb)
    );

    read_mux rmux_inst (
        .clk       (clk),
        .rst       (rst),
        .load_en   (load_en),
        .cs        (cs),
        .rom_data  (rom_data),
        .ram_data  (ram_data),
        .char_dout (char_dout),
        .pal_dout  (pal_dout),
        .obj_dout  (obj_dout),
        .io_dout   (io_dout),
        .rdata     (rdata)
    );

endmodule

// File: read_mux.sv
/* Registered data-in bus to the master.
   Loads once per cycle and holds until the next load. */
`timescale 1ns/1ps

module read_mux (
    input  logic              clk,
    input  logic              rst,
    input  logic              load_en,
    input  main_bus_pkg::cs_t cs,
    input  logic [15:0]       rom_data,
    input  logic [15:0]       ram_data,
    input  logic [15:0]       char_dout,
    input  logic [15:0]       pal_dout,
    input  logic [15:0]       obj_dout,
    input  logic [7:0]        io_dout,
    output logic [15:0]       rdata
);
    import main_bus_pkg::*;

    logic [15:0] src;

    // Selects are one-hot, order does not matter
    always_comb begin
        if (cs.rom)
            src = rom_data;
        else if (cs.ram || cs.vram)
            src = ram_data;
        else if (cs.chr)
            src = char_dout;
        else if (cs.pal)
            src = pal_dout;
        else if (cs.obj)
            src = obj_dout;
        else if (cs.io)
            src = {8'hff, io_dout};  // Cabinet is 8 bits wide
        else
            src = open_bus;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata <= 16'd0;
        end else if (load_en) begin
            rdata <= src;
        end
    end

endmodule

// File: cab_io.sv
/* Cabinet I/O: output port latch and the switch, DIP and ADC reads.
   Only port 0 of group 0 is writable, through the low byte.
   The ADC read follows the channel held in the latch, with no conversion delay. */
`timescale 1ns/1ps

module cab_io (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   io_cs,
    input  logic                   wr_stb,
    input  main_bus_pkg::bus_req_t req,
    input  logic [7:0]             joystick1,
    input  logic [1:0]             coin_input,
    input  logic [1:0]             start_button,
    input  logic                   service,
    input  logic                   dip_test,
    input  logic [7:0]             dipsw_a,
    input  logic [7:0]             dipsw_b,
    input  logic [15:0]            joyana1,
    input  logic [15:0]            joyana2,
    output logic [7:0]             io_dout,
    output logic [1:0]             obj_cfg,
    output logic                   video_en,
    output logic                   snd_rstb
);
    import main_bus_pkg::*;

    logic [7:0] port_latch;
    logic [2:0] adc_ch;
    logic       latch_we;

    assign latch_we = wr_stb && io_cs && !req.dsn[0]
                   && req.addr[6:4] == 3'd0 && req.addr[2:1] == 2'd0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            port_latch <= 8'd0;
        end else if (latch_we) begin
            port_latch <= req.wdata[7:0];
        end
    end

    assign obj_cfg  = port_latch[7:6];  // Object engine and colour mixer
    assign video_en = port_latch[5];
    assign adc_ch   = port_latch[4:2];
    assign snd_rstb = port_latch[0];

    always_comb begin
        io_dout = 8'hff;
        case (req.addr[6:4])
            3'd0: io_dout = port_latch;
            3'd1: begin
                case (req.addr[2:1])
                    2'd0: io_dout = {coin_input, 1'b0, joystick1[4], start_button[0],
                                     service, dip_test, 1'b1};
                    2'd1: io_dout = 8'hff;
                    2'd2: io_dout = dipsw_a;
                    default: io_dout = dipsw_b;
                endcase
            end
            3'd3: begin
                case (adc_ch)
                    3'd0: io_dout = joyana1[7:0];               // Wheel
                    3'd1: io_dout = joyana1[15:8] + adc_bias;   // Gas
                    3'd2: io_dout = joyana2[15:8] + adc_bias;   // Brake
                    default: io_dout = 8'hff;
                endcase
            end
            default: io_dout = 8'hff;
        endcase
    end

endmodule

// File: region_decoder.sv
/* Fixed address map to region and one-hot chip select, registered per cycle.
   ROM writes, and RAM or VRAM cycles with both data strobes high, end as none.
   The request must be stable during decode_en. */
`timescale 1ns/1ps

module region_decoder (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   decode_en,
    input  logic                   cycle_end,
    input  main_bus_pkg::bus_req_t req,
    output main_bus_pkg::region_e  region,
    output main_bus_pkg::cs_t      cs
);
    import main_bus_pkg::*;

    region_e region_nx;
    cs_t     cs_nx;
    logic    any_ds;

    assign any_ds = ~&req.dsn;

    always_comb begin
        region_nx = reg_none;
        cs_nx     = '0;
        case (req.addr[23:21])
            map_rom: begin
                if (req.rnw) begin
                    region_nx = reg_rom;
                    cs_nx.rom = 1'b1;
                end
            end
            map_ram: begin
                if (any_ds) begin
                    region_nx = reg_ram;
                    cs_nx.ram = 1'b1;
                end
            end
            map_scr: begin
                if (req.addr[16]) begin
                    region_nx = reg_scr;
                    cs_nx.chr = 1'b1;   // Character RAM
                end else if (any_ds) begin
                    region_nx  = reg_scr;
                    cs_nx.vram = 1'b1;  // Shares the RAM port
                end
            end
            map_pal: begin
                region_nx = reg_pal;
                cs_nx.pal = 1'b1;
            end
            map_obj: begin
                region_nx = reg_obj;
                cs_nx.obj = 1'b1;
            end
            map_io: begin
                region_nx = reg_io;
                cs_nx.io  = 1'b1;
            end
            default: ;
        endcase
        if (region_nx == reg_none) cs_nx.none = 1'b1; // Unmapped or refused
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            region <= reg_none;
            cs     <= '0;
        end else if (cycle_end) begin
            region <= reg_none;
            cs     <= '0;
        end else if (decode_en) begin
            region <= region_nx;
            cs     <= cs_nx;
        end
    end

endmodule

// File: wait_timer.sv
/* Fixed wait states for on-board regions.
   timer_done stays high while idle, so it only means something after a start. */
`timescale 1ns/1ps

module wait_timer (
    input  logic clk,
    input  logic rst,
    input  logic timer_start,
    output logic timer_done
);
    import main_bus_pkg::*;

    logic [1:0] count;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= 2'd0;
        end else if (timer_start) begin
            count <= fixed_wait;
        end else if (count != 2'd0) begin
            count <= count - 2'd1;  // Stops at zero
        end
    end

    // A pending load hides the old zero count
    assign timer_done = (count == 2'd0) && !timer_start;

endmodule

// File: bus_cycle_fsm.sv
/* Sequences one bus cycle from address strobe to acknowledge release.
   The master must keep asn low until dtackn falls; an early release is not handled.
   ROM and RAM end on their ok level, everything else on the wait timer. */
`timescale 1ns/1ps

module bus_cycle_fsm (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 asn,
    input  main_bus_pkg::region_e region,
    input  logic                 rnw,
    input  logic                 rom_ok,
    input  logic                 ram_ok,
    input  logic                 timer_done,
    output logic                 decode_en,
    output logic                 timer_start,
    output logic                 load_en,
    output logic                 cycle_end,
    output logic                 dtackn
);
    import main_bus_pkg::*;

    cycle_state_e state;
    cycle_state_e state_nx;
    logic         wait_done;

    // Which condition closes st_wait
    always_comb begin
        case (region)
            reg_rom: wait_done = rnw ? rom_ok : timer_done; // Writes never see rom_ok
            reg_ram: wait_done = ram_ok;
            default: wait_done = timer_done;
        endcase
    end

    always_comb begin
        state_nx = state;
        case (state)
            st_idle: begin
                if (!asn) state_nx = st_decode;
            end
            st_decode: state_nx = st_wait;
            st_wait: begin
                if (wait_done) state_nx = st_ack;
            end
            st_ack: begin
                if (asn) state_nx = st_idle;   // Master has seen dtackn
            end
            default: state_nx = st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_nx;
        end
    end

    assign decode_en   = (state == st_decode);
    assign timer_start = (state == st_decode);  // Timer runs from wait entry
    assign load_en     = (state == st_wait) && wait_done;
    assign cycle_end   = (state == st_ack) && asn;
    assign dtackn      = (state != st_ack);

endmodule

// File: main_bus_pkg.sv
/* Shared types and constants of the main-CPU bus glue.
   The region map is fixed and word addressed (bits 23 to 1), no mapper.
   Wait-state count and open-bus value apply to every on-board device. */
package main_bus_pkg;

    // Target region of one bus cycle
    typedef enum logic [2:0] {
        reg_rom,
        reg_ram,
        reg_scr,
        reg_pal,
        reg_obj,
        reg_io,
        reg_none
    } region_e;

    // Bus cycle sequencing
    typedef enum logic [1:0] {
        st_idle,
        st_decode,
        st_wait,
        st_ack
    } cycle_state_e;

    // One cycle as presented by the master, held while asn is low
    typedef struct packed {
        logic [23:1] addr;
        logic [15:0] wdata;
        logic [1:0]  dsn;   // Upper, lower, active low
        logic        rnw;
    } bus_req_t;

    // One select per device, at most one set
    typedef struct packed {
        logic rom;
        logic ram;
        logic chr;
        logic vram;
        logic pal;
        logic obj;
        logic io;
        logic none;
    } cs_t;

    localparam logic [1:0]  fixed_wait = 2'd2;      // On-board devices
    localparam logic [15:0] open_bus   = 16'hffff;
    localparam logic [7:0]  adc_bias   = 8'h80;     // Pedal offset

    // Address bits 23..21
    localparam logic [2:0] map_rom = 3'd0;
    localparam logic [2:0] map_ram = 3'd1;
    localparam logic [2:0] map_scr = 3'd2;
    localparam logic [2:0] map_pal = 3'd3;
    localparam logic [2:0] map_obj = 3'd4;
    localparam logic [2:0] map_io  = 3'd5;

endpackage
